// File: common/uart_echo_pkg.sv
`default_nettype none

package uart_echo_pkg;

    ///////////////////////////////
    // Frame and timing constants
    ///////////////////////////////

    // Clocks per oversampling tick, so one bit is 64 clocks
    localparam int TICK_DIV = 4;

    // Ticks per bit period
    localparam int OVERSAMPLE = 16;

    // 8N1 frame, LSB first
    localparam int DATA_BITS = 8;

    // Echo queue entries
    localparam int QUEUE_DEPTH = 4;

    ///////////////////////////////
    // Receiver to queue payload
    ///////////////////////////////

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 frame_err;   // Stop bit sampled low
    } rx_byte_t;

endpackage

`default_nettype wire

// File: design/baud_tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

module baud_tick_gen (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    logic [$clog2(uart_echo_pkg::TICK_DIV)-1:0] div_cnt;

    // Free-running divider, one tick pulse per wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt == uart_echo_pkg::TICK_DIV - 1) begin
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: uart_rx/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     tick,
    input  wire                     rx,
    output uart_echo_pkg::rx_byte_t rx_byte,
    output logic                    rx_strobe,
    output logic                    frame_err
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic sample_pt;

    logic [$clog2(uart_echo_pkg::OVERSAMPLE)-1:0] tick_cnt;
    logic [$clog2(uart_echo_pkg::DATA_BITS)-1:0]  bit_cnt;
    logic [uart_echo_pkg::DATA_BITS-1:0]          shift_reg;

    ///////////////////////////////
    // Input synchronizer
    ///////////////////////////////

    // Idle line is high, so the flops come out of reset high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Middle of a data or stop bit
    assign sample_pt = tick && (tick_cnt == uart_echo_pkg::OVERSAMPLE - 1);

    ///////////////////////////////
    // Frame FSM
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_IDLE;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Falling edge opens a start bit
                    if (rx_prev && !rx_sync) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (tick_cnt == uart_echo_pkg::OVERSAMPLE / 2 - 1) begin
                            // Glitch if the line is back high at mid start bit
                            state    <= rx_sync ? RX_IDLE : RX_DATA;
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (sample_pt) begin
                        tick_cnt <= '0;
                        if (bit_cnt == uart_echo_pkg::DATA_BITS - 1) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (sample_pt) begin
                        state     <= RX_IDLE;
                        tick_cnt  <= '0;
                        rx_strobe <= 1'b1;
                        frame_err <= !rx_sync;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample_pt) begin
            shift_reg <= {rx_sync, shift_reg[uart_echo_pkg::DATA_BITS-1:1]};
        end
        if (state == RX_STOP && sample_pt) begin
            rx_byte.data      <= shift_reg;
            rx_byte.frame_err <= !rx_sync;
        end
    end

    // At most one strobe per frame
    a_strobe_single: assert property (@(posedge clk) disable iff (rst)
        rx_strobe |=> !rx_strobe);

endmodule

`default_nettype wire

// File: uart_tx/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                start_trig,
    input  wire [uart_echo_pkg::DATA_BITS-1:0] tx_data,
    input  wire                                tick,
    output logic                               tx,
    output logic                               tx_busy,
    output logic                               tx_done
);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t state, state_n;

    logic tx_n;
    logic tx_busy_n;
    logic tx_done_n;
    logic bit_end;

    logic [$clog2(uart_echo_pkg::OVERSAMPLE)-1:0] tick_cnt, tick_cnt_n;
    logic [$clog2(uart_echo_pkg::DATA_BITS)-1:0]  bit_cnt, bit_cnt_n;
    logic [uart_echo_pkg::DATA_BITS-1:0]          data_buf, data_buf_n;

    // Last tick of the current bit period
    assign bit_end = tick && (tick_cnt == uart_echo_pkg::OVERSAMPLE - 1);

    ///////////////////////////////
    // State and output registers
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
            tx_done  <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            state    <= state_n;
            tx       <= tx_n;
            tx_busy  <= tx_busy_n;
            tx_done  <= tx_done_n;
            tick_cnt <= tick_cnt_n;
            bit_cnt  <= bit_cnt_n;
        end
    end

    always_ff @(posedge clk) begin
        data_buf <= data_buf_n;
    end

    ///////////////////////////////
    // Next state logic
    ///////////////////////////////

    always_comb begin
        state_n    = state;
        tx_n       = tx;
        tx_busy_n  = tx_busy;
        tx_done_n  = 1'b0;
        tick_cnt_n = tick_cnt;
        bit_cnt_n  = bit_cnt;
        data_buf_n = data_buf;

        if (tick && !bit_end) begin
            tick_cnt_n = tick_cnt + 1'b1;
        end

        case (state)
            TX_IDLE: begin
                tx_n       = 1'b1;
                tx_busy_n  = 1'b0;
                tick_cnt_n = '0;
                if (start_trig) begin
                    state_n    = TX_START;
                    data_buf_n = tx_data;
                    tx_n       = 1'b0;
                    tx_busy_n  = 1'b1;
                end
            end
            TX_START: begin
                if (bit_end) begin
                    state_n    = TX_DATA;
                    tick_cnt_n = '0;
                    bit_cnt_n  = '0;
                    tx_n       = data_buf[0];
                end
            end
            TX_DATA: begin
                if (bit_end) begin
                    tick_cnt_n = '0;
                    if (bit_cnt == uart_echo_pkg::DATA_BITS - 1) begin
                        state_n = TX_STOP;
                        tx_n    = 1'b1;
                    end else begin
                        bit_cnt_n  = bit_cnt + 1'b1;
                        data_buf_n = data_buf >> 1;
                        tx_n       = data_buf[1];
                    end
                end
            end
            TX_STOP: begin
                if (bit_end) begin
                    state_n    = TX_IDLE;
                    tick_cnt_n = '0;
                    tx_busy_n  = 1'b0;
                    tx_done_n  = 1'b1;
                end
            end
            default: state_n = TX_IDLE;
        endcase
    end

    // Line idles high between frames
    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        !tx_busy |-> tx);

endmodule

`default_nettype wire

// File: design/echo_queue.sv
`timescale 1ns/100ps
`default_nettype none

module echo_queue (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire uart_echo_pkg::rx_byte_t        rx_byte,
    input  wire                                 rx_strobe,
    input  wire                                 tx_busy,
    output logic                                start_trig,
    output logic [uart_echo_pkg::DATA_BITS-1:0] tx_data
);

    logic [uart_echo_pkg::DATA_BITS-1:0] mem [uart_echo_pkg::QUEUE_DEPTH];

    logic [$clog2(uart_echo_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(uart_echo_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(uart_echo_pkg::QUEUE_DEPTH+1)-1:0] count;

    logic push;
    logic start_prev;

    // Bytes with a bad stop bit are dropped here
    assign push = rx_strobe && !rx_byte.frame_err;

    // Issue while the transmitter is idle, never twice in a row
    assign start_trig = (count != '0) && !tx_busy && !start_prev;
    assign tx_data    = mem[rd_ptr];

    ///////////////////////////////
    // Pointers and count
    ///////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            start_prev <= 1'b0;
        end else begin
            start_prev <= start_trig;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (start_trig) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !start_trig) begin
                count <= count + 1'b1;
            end else if (!push && start_trig) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_byte.data;
        end
    end

    // Echo drains as fast as bytes arrive
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> (count != uart_echo_pkg::QUEUE_DEPTH) || start_trig);

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        tx_busy |-> !start_trig);

endmodule

`default_nettype wire

// File: design/uart_echo_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_echo_top (
    input  wire  clk,
    input  wire  rst,
    input  wire  rx,
    output logic tx,
    output logic tx_busy,
    output logic frame_err
);

    logic                                tick;
    uart_echo_pkg::rx_byte_t             rx_byte;
    logic                                rx_strobe;
    logic                                start_trig;
    logic [uart_echo_pkg::DATA_BITS-1:0] tx_data;

    // Shared 16x tick for both directions
    baud_tick_gen u_baud_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .rx        (rx),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .frame_err (frame_err)
    );

    echo_queue u_echo_queue (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .tx_busy    (tx_busy),
        .start_trig (start_trig),
        .tx_data    (tx_data)
    );

    // Done pulse has no consumer here, busy paces the queue
    uart_tx u_uart_tx (
        .clk        (clk),
        .rst        (rst),
        .start_trig (start_trig),
        .tx_data    (tx_data),
        .tick       (tick),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .tx_done    ()
    );

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    // 100 ns period
    localparam real HALF_PERIOD = 50.0;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_uart_echo.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_echo;

    localparam int BIT_CLKS    = uart_echo_pkg::TICK_DIV * uart_echo_pkg::OVERSAMPLE;
    localparam int FRAME_CLKS  = 10 * BIT_CLKS;
    localparam int NUM_ENTRIES = 16;
    localparam int NUM_FIXED   = 12;

    typedef struct packed {
        logic [7:0] data;
        logic       bad_stop;
        logic [7:0] gap;      // Idle bits before the frame
    } frame_entry_t;

    logic clk;
    logic rst;
    logic rx;
    logic tx;
    logic tx_busy;
    logic frame_err;

    frame_entry_t stim [NUM_ENTRIES];
    logic [7:0]   exp_q [$];

    int     mismatch_cnt = 0;
    int     fail_cnt     = 0;
    int     echo_cnt     = 0;
    int     ferr_cnt     = 0;
    int     good_total   = 0;
    int     bad_total    = 0;
    int     cycle_cnt    = 0;
    int     cycle_limit  = 100000;
    integer seed;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    uart_echo_top DUT (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .tx        (tx),
        .tx_busy   (tx_busy),
        .frame_err (frame_err)
    );

    //////////////////////////////
    // Serial driver
    //////////////////////////////

    // Hold one bit for a full bit period
    task automatic drive_bit(input logic b);
        @(negedge clk);
        rx = b;
        repeat (BIT_CLKS - 1) @(negedge clk);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(!bad_stop);
    endtask

    task automatic check_idle();
        assert (tx === 1'b1 && tx_busy === 1'b0) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: line not idle, tx=%b tx_busy=%b", $time, tx, tx_busy);
        end
    endtask

    //////////////////////////////
    // Echo monitor
    //////////////////////////////

    initial begin : echo_monitor
        logic [7:0] got;
        logic [7:0] exp;
        logic       line_prev;
        line_prev = 1'b1;
        forever begin
            @(negedge clk);
            if (!rst && line_prev && !tx) begin
                // Middle of the start bit
                repeat (BIT_CLKS / 2 - 1) @(negedge clk);
                assert (tx == 1'b0 && tx_busy === 1'b1) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: echo start bit tx=%b tx_busy=%b", $time, tx,
                             tx_busy);
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    got[b] = tx;
                end
                repeat (BIT_CLKS) @(negedge clk);
                assert (tx == 1'b1) else begin
                    mismatch_cnt++;
                    $display("Mismatch at %0t: echo stop bit low for byte %02h", $time, got);
                end
                if (exp_q.size() == 0) begin
                    fail_cnt++;
                    $display("Echo of byte %02h arrived with no byte pending", got);
                end else begin
                    exp = exp_q.pop_front();
                    assert (got == exp) else begin
                        mismatch_cnt++;
                        $display("Mismatch at %0t: echoed %02h, expected %02h", $time, got, exp);
                    end
                end
                echo_cnt++;
            end
            line_prev = tx;
        end
    end

    // Count framing error pulses
    always @(negedge clk) begin
        if (!rst && frame_err) begin
            ferr_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            fail_cnt++;
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d mismatches, %0d other", mismatch_cnt, fail_cnt);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin : main_seq
        int         ferr_before;
        int         gap_clks;
        logic [31:0] rnd;
        rst  = 1'b1;
        rx   = 1'b1;
        seed = 78656;

        // Long gaps, then back to back, then bad stop bits
        stim[0]  = '{8'h55, 1'b0, 8'd4};
        stim[1]  = '{8'hA3, 1'b0, 8'd20};
        stim[2]  = '{8'h00, 1'b0, 8'd20};
        stim[3]  = '{8'hFF, 1'b0, 8'd20};
        stim[4]  = '{8'h01, 1'b0, 8'd0};
        stim[5]  = '{8'h80, 1'b0, 8'd0};
        stim[6]  = '{8'h3C, 1'b0, 8'd0};
        stim[7]  = '{8'hC5, 1'b0, 8'd0};
        stim[8]  = '{8'h5A, 1'b0, 8'd0};
        stim[9]  = '{8'h7E, 1'b1, 8'd2};
        stim[10] = '{8'h96, 1'b0, 8'd1};
        stim[11] = '{8'hE1, 1'b1, 8'd0};
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            rnd = $random(seed);
            // A frame after a low stop bit needs an idle bit for its edge
            stim[i] = '{rnd[7:0], (i == 13), (i % 2 == 0) ? 8'd1 : 8'd0};
        end

        gap_clks = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            gap_clks += stim[i].gap * BIT_CLKS;
            if (stim[i].bad_stop) begin
                bad_total++;
            end else begin
                good_total++;
            end
        end
        cycle_limit = NUM_ENTRIES * 2 * FRAME_CLKS + gap_clks + 2000;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_idle();

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            repeat (stim[i].gap) drive_bit(1'b1);
            if (i == 0) begin
                check_idle();
            end
            if (!stim[i].bad_stop) begin
                exp_q.push_back(stim[i].data);
            end
            ferr_before = ferr_cnt;
            send_frame(stim[i].data, stim[i].bad_stop);
            assert (ferr_cnt - ferr_before == int'(stim[i].bad_stop)) else begin
                mismatch_cnt++;
                $display("Mismatch at %0t: entry %0d gave %0d framing pulses", $time, i,
                         ferr_cnt - ferr_before);
            end
        end
        drive_bit(1'b1);

        // Drain, then watch for stray echoes
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2 * FRAME_CLKS) @(negedge clk);

        assert (ferr_cnt == bad_total) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %0d framing pulses, expected %0d", $time, ferr_cnt,
                     bad_total);
        end
        assert (echo_cnt == good_total) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %0d echoes, expected %0d", $time, echo_cnt, good_total);
        end
        check_idle();

        $display("Errors: %0d mismatches, %0d other, %0d echoes, %0d framing errors",
                 mismatch_cnt, fail_cnt, echo_cnt, ferr_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_echo.f
common/uart_echo_pkg.sv
design/baud_tick_gen.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
design/echo_queue.sv
design/uart_echo_top.sv
verif/tb_clock_gen.sv
verif/tb_uart_echo.sv

// File: Bender.yml
package:
  name: uart_echo

sources:
  # Shared package first
  - common/uart_echo_pkg.sv
  # Serial blocks and queue
  - design/baud_tick_gen.sv
  - uart_rx/uart_rx.sv
  - uart_tx/uart_tx.sv
  - design/echo_queue.sv
  # Top level
  - design/uart_echo_top.sv
  # Testbench
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_uart_echo.sv
